//--- src/recorderPkg.sv
`default_nettype none

package recorderPkg;

	// number of message slots on the front panel
	localparam int SlotCount = 5;

	typedef logic [2:0] SlotIndex;

	// one audio sample from the codec
	typedef logic [7:0] Sample;

	// length or offset within a slot, up to 64 samples
	typedef logic [6:0] SampleCount;

	typedef logic [1:0] Mode;

	// menu positions, in up order
	localparam Mode ModePlay = 2'd0;
	localparam Mode ModeRecord = 2'd1;
	localparam Mode ModeDelete = 2'd2;
	localparam Mode ModeDeleteAll = 2'd3;

	typedef enum logic [3:0] {
		idle,
		menu,
		playMenu,
		playing,
		skipping,
		recordStart,
		recording,
		recordDone,
		deleteMenu,
		deleteAll,
		memFullShow
	} ControlState;

endpackage

`default_nettype wire

//--- src/buttonDebounce.sv
`timescale 1ns/1ns
`default_nettype none

module buttonDebounce #(
	parameter int DebounceCycles = 4
) (
	input wire logic clkout,
	input wire logic reset,
	input wire logic btnUp,
	input wire logic btnDown,
	input wire logic btnCentre,
	input wire logic btnLeft,
	input wire logic btnRight,
	output logic upPress,
	output logic downPress,
	output logic centrePress,
	output logic leftPress,
	output logic rightPress
);

	localparam int ButtonCount = 5;
	localparam int CountWidth = $clog2(DebounceCycles + 1);

	logic [ButtonCount-1:0] raw;
	logic [ButtonCount-1:0] synced;
	logic [ButtonCount-1:0] level;
	logic [ButtonCount-1:0] levelPrev;
	logic [ButtonCount-1:0] press;
	logic [CountWidth-1:0] stableCount [ButtonCount];

	assign raw = {btnRight, btnLeft, btnCentre, btnDown, btnUp};

	always_ff @(posedge clkout) begin
		if (!reset) begin
			synced <= '0;
			level <= '0;
			levelPrev <= '0;
			press <= '0;
			for (int i = 0; i < ButtonCount; i++) begin
				stableCount[i] <= '0;
			end
		end else begin
			synced <= raw;
			levelPrev <= level;
			// act on release of the button
			press <= levelPrev & ~level;
			for (int i = 0; i < ButtonCount; i++) begin
				if (synced[i] == level[i]) begin
					stableCount[i] <= '0;
				end else if (stableCount[i] == CountWidth'(DebounceCycles - 1)) begin
					level[i] <= synced[i];
					stableCount[i] <= '0;
				end else begin
					stableCount[i] <= stableCount[i] + 1'b1;
				end
			end
		end
	end

	assign upPress = press[0];
	assign downPress = press[1];
	assign centrePress = press[2];
	assign leftPress = press[3];
	assign rightPress = press[4];

endmodule

`default_nettype wire

//--- src/messageTable.sv
`timescale 1ns/1ns
`default_nettype none

module messageTable #(
	parameter int SlotDepth = 16
) (
	input wire logic clkout,
	input wire logic reset,
	input wire logic commit,
	input wire logic clearOne,
	input wire logic clearAll,
	input wire recorderPkg::SlotIndex writeSlot,
	input wire recorderPkg::SlotIndex selected,
	input wire recorderPkg::SampleCount commitLength,
	output logic [recorderPkg::SlotCount-1:0] slotValid,
	output recorderPkg::SlotIndex freeSlot,
	output recorderPkg::SlotIndex nextValid,
	output logic anyFree,
	output logic nextFound,
	output recorderPkg::SampleCount selectedLength
);

	logic [recorderPkg::SlotCount-1:0] valid;
	recorderPkg::SampleCount lengths [recorderPkg::SlotCount];

	assign slotValid = valid;
	assign selectedLength = lengths[selected];

	always_ff @(posedge clkout) begin
		if (!reset) begin
			valid <= '0;
		end else if (clearAll) begin
			valid <= '0;
		end else begin
			// delete works on the slot shown in the menu
			if (clearOne) begin
				valid[selected] <= 1'b0;
			end
			if (commit) begin
				valid[writeSlot] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clkout) begin
		if (commit) begin
			lengths[writeSlot] <= commitLength;
		end
	end

	////////////////////////////////////////////////////////////////////
	// priority search, walking down so the lowest match wins
	always_comb begin
		freeSlot = '0;
		anyFree = 1'b0;
		nextValid = '0;
		nextFound = 1'b0;
		for (int i = recorderPkg::SlotCount - 1; i >= 0; i--) begin
			if (!valid[i]) begin
				freeSlot = recorderPkg::SlotIndex'(i);
				anyFree = 1'b1;
			end
			if (valid[i] && recorderPkg::SlotIndex'(i) > selected) begin
				nextValid = recorderPkg::SlotIndex'(i);
				nextFound = 1'b1;
			end
		end
	end

	// the recorder only ever claims a free slot
	commitToFreeSlot: assert property (@(posedge clkout) disable iff (!reset)
		commit |-> !valid[writeSlot]);

	commitLengthFits: assert property (@(posedge clkout) disable iff (!reset)
		commit |-> commitLength <= recorderPkg::SampleCount'(SlotDepth));

endmodule

`default_nettype wire

//--- src/sampleMemory.sv
`timescale 1ns/1ns
`default_nettype none

module sampleMemory #(
	parameter int SlotDepth = 16
) (
	input wire logic clkout,
	input wire logic writeEnable,
	input wire logic readEnable,
	input wire recorderPkg::SlotIndex slot,
	input wire recorderPkg::SampleCount offset,
	input wire recorderPkg::Sample writeData,
	output recorderPkg::Sample readData
);

	localparam int Words = recorderPkg::SlotCount * SlotDepth;
	localparam int AddrWidth = $clog2(Words);

	recorderPkg::Sample storage [Words];
	logic [AddrWidth-1:0] address;

	// slots sit back to back, SlotDepth samples each
	assign address = AddrWidth'(int'(slot) * SlotDepth + int'(offset));

	always_ff @(posedge clkout) begin
		if (writeEnable) begin
			storage[address] <= writeData;
		end
	end

	// registered read, data one cycle after the request
	always_ff @(posedge clkout) begin
		if (readEnable) begin
			readData <= storage[address];
		end
	end

	// one port address, so record and play never share a cycle
	singleAccess: assert property (@(posedge clkout)
		!(writeEnable && readEnable));

endmodule

`default_nettype wire

//--- src/recorderControl.sv
`timescale 1ns/1ns
`default_nettype none

module recorderControl #(
	parameter int SlotDepth = 16
) (
	input wire logic clkout,
	input wire logic reset,
	input wire logic upPress,
	input wire logic downPress,
	input wire logic centrePress,
	input wire logic leftPress,
	input wire logic rightPress,
	input wire logic sampleStrobe,
	input wire recorderPkg::Sample sampleIn,
	input wire recorderPkg::Sample readData,
	input wire logic [recorderPkg::SlotCount-1:0] slotValid,
	input wire recorderPkg::SlotIndex freeSlot,
	input wire recorderPkg::SlotIndex nextValid,
	input wire logic anyFree,
	input wire logic nextFound,
	input wire recorderPkg::SampleCount selectedLength,
	output recorderPkg::Mode mode,
	output recorderPkg::SlotIndex selected,
	output logic recording,
	output logic memFull,
	output logic writeEnable,
	output logic readEnable,
	output logic commit,
	output logic clearOne,
	output logic clearAll,
	output recorderPkg::SlotIndex memSlot,
	output recorderPkg::SampleCount memOffset,
	output recorderPkg::SampleCount commitLength,
	output recorderPkg::Sample writeData,
	output recorderPkg::Sample sampleOut,
	output logic sampleOutStrobe
);

	localparam recorderPkg::SampleCount LastOffset = recorderPkg::SampleCount'(SlotDepth - 1);
	localparam recorderPkg::SampleCount FullCount = recorderPkg::SampleCount'(SlotDepth);
	localparam recorderPkg::SlotIndex LastSlot =
		recorderPkg::SlotIndex'(recorderPkg::SlotCount - 1);

	recorderPkg::ControlState state;
	recorderPkg::SampleCount cursor;
	logic readPending;

	// up and down through the slots, held at both ends
	function automatic recorderPkg::SlotIndex stepSelect(input recorderPkg::SlotIndex current,
			input logic up, input logic down);
		if (up && current != LastSlot) begin
			return current + 1'b1;
		end
		if (down && current != '0) begin
			return current - 1'b1;
		end
		return current;
	endfunction

	////////////////////////////////////////////////////////////////////
	// strobes and status decoded from the state
	assign recording = state == recorderPkg::recording;
	assign memFull = state == recorderPkg::memFullShow;
	assign writeEnable = recording && sampleStrobe && !leftPress;
	assign readEnable = (state == recorderPkg::playing) && sampleStrobe &&
		cursor != selectedLength && !leftPress && !rightPress;
	assign commit = state == recorderPkg::recordDone;
	assign clearOne = (state == recorderPkg::deleteMenu) && centrePress;
	assign clearAll = state == recorderPkg::deleteAll;

	assign memOffset = cursor;
	assign commitLength = cursor;
	assign writeData = sampleIn;

	////////////////////////////////////////////////////////////////////
	// menu FSM
	always_ff @(posedge clkout) begin
		if (!reset) begin
			state <= recorderPkg::idle;
			mode <= recorderPkg::ModePlay;
			selected <= '0;
			cursor <= '0;
			memSlot <= '0;
		end else begin
			unique case (state)
				recorderPkg::idle: begin
					if (upPress && mode != recorderPkg::ModeDeleteAll) begin
						mode <= mode + 1'b1;
					end else if (downPress && mode != recorderPkg::ModePlay) begin
						mode <= mode - 1'b1;
					end else if (centrePress) begin
						state <= recorderPkg::menu;
					end
				end
				recorderPkg::menu: begin
					unique case (mode)
						recorderPkg::ModePlay: state <= recorderPkg::playMenu;
						recorderPkg::ModeRecord: state <= recorderPkg::recordStart;
						recorderPkg::ModeDelete: state <= recorderPkg::deleteMenu;
						default: state <= recorderPkg::deleteAll;
					endcase
				end
				recorderPkg::playMenu: begin
					selected <= stepSelect(selected, upPress, downPress);
					if (centrePress && slotValid[selected]) begin
						memSlot <= selected;
						cursor <= '0;
						state <= recorderPkg::playing;
					end else if (leftPress) begin
						state <= recorderPkg::idle;
					end
				end
				recorderPkg::playing: begin
					if (leftPress) begin
						state <= recorderPkg::playMenu;
					end else if (rightPress) begin
						state <= recorderPkg::skipping;
					end else if (cursor == selectedLength) begin
						state <= recorderPkg::playMenu;
					end else if (readEnable) begin
						cursor <= cursor + 1'b1;
					end
				end
				recorderPkg::skipping: begin
					// nothing valid above, so back to choosing
					if (nextFound) begin
						selected <= nextValid;
						memSlot <= nextValid;
						cursor <= '0;
						state <= recorderPkg::playing;
					end else begin
						state <= recorderPkg::playMenu;
					end
				end
				recorderPkg::recordStart: begin
					if (anyFree) begin
						memSlot <= freeSlot;
						cursor <= '0;
						state <= recorderPkg::recording;
					end else begin
						state <= recorderPkg::memFullShow;
					end
				end
				recorderPkg::recording: begin
					if (leftPress) begin
						state <= recorderPkg::recordDone;
					end else if (writeEnable) begin
						cursor <= cursor + 1'b1;
						// last sample fills the slot
						if (cursor == LastOffset) begin
							state <= recorderPkg::recordDone;
						end
					end
				end
				recorderPkg::recordDone: begin
					state <= recorderPkg::idle;
				end
				recorderPkg::deleteMenu: begin
					selected <= stepSelect(selected, upPress, downPress);
					if (leftPress) begin
						state <= recorderPkg::idle;
					end
				end
				recorderPkg::deleteAll: begin
					state <= recorderPkg::idle;
				end
				recorderPkg::memFullShow: begin
					if (leftPress) begin
						state <= recorderPkg::idle;
					end
				end
				default: begin
					state <= recorderPkg::idle;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////
	// playback output, two cycles after the strobe
	always_ff @(posedge clkout) begin
		if (!reset) begin
			readPending <= 1'b0;
			sampleOutStrobe <= 1'b0;
		end else begin
			readPending <= readEnable;
			sampleOutStrobe <= readPending;
		end
	end

	always_ff @(posedge clkout) begin
		if (readPending) begin
			sampleOut <= readData;
		end
	end

	// no playback sample may still be in flight once recording starts
	recordExcludesPlay: assert property (@(posedge clkout) disable iff (!reset)
		recording |-> !readPending && !sampleOutStrobe);

	cursorInSlot: assert property (@(posedge clkout) disable iff (!reset)
		cursor <= FullCount);

endmodule

`default_nettype wire

//--- src/voiceRecorder.sv
`timescale 1ns/1ns
`default_nettype none

module voiceRecorder #(
	parameter int SlotDepth = 16,
	parameter int DebounceCycles = 4
) (
	input wire logic clkout,
	input wire logic reset,
	input wire logic btnUp,
	input wire logic btnDown,
	input wire logic btnCentre,
	input wire logic btnLeft,
	input wire logic btnRight,
	input wire logic sampleStrobe,
	input wire recorderPkg::Sample sampleIn,
	output recorderPkg::Sample sampleOut,
	output logic sampleOutStrobe,
	output logic recording,
	output logic memFull,
	output recorderPkg::Mode mode,
	output recorderPkg::SlotIndex selected,
	output logic [recorderPkg::SlotCount-1:0] slotValid
);

	// release strobes
	logic upPress;
	logic downPress;
	logic centrePress;
	logic leftPress;
	logic rightPress;

	// sample memory side
	logic writeEnable;
	logic readEnable;
	recorderPkg::SlotIndex memSlot;
	recorderPkg::SampleCount memOffset;
	recorderPkg::Sample writeData;
	recorderPkg::Sample readData;

	// slot table side
	logic commit;
	logic clearOne;
	logic clearAll;
	recorderPkg::SampleCount commitLength;
	recorderPkg::SlotIndex freeSlot;
	recorderPkg::SlotIndex nextValid;
	logic anyFree;
	logic nextFound;
	recorderPkg::SampleCount selectedLength;

	buttonDebounce #(
		.DebounceCycles(DebounceCycles)
	) debouncer (
		.clkout(clkout),
		.reset(reset),
		.btnUp(btnUp),
		.btnDown(btnDown),
		.btnCentre(btnCentre),
		.btnLeft(btnLeft),
		.btnRight(btnRight),
		.upPress(upPress),
		.downPress(downPress),
		.centrePress(centrePress),
		.leftPress(leftPress),
		.rightPress(rightPress)
	);

	recorderControl #(
		.SlotDepth(SlotDepth)
	) control (
		.clkout(clkout),
		.reset(reset),
		.upPress(upPress),
		.downPress(downPress),
		.centrePress(centrePress),
		.leftPress(leftPress),
		.rightPress(rightPress),
		.sampleStrobe(sampleStrobe),
		.sampleIn(sampleIn),
		.readData(readData),
		.slotValid(slotValid),
		.freeSlot(freeSlot),
		.nextValid(nextValid),
		.anyFree(anyFree),
		.nextFound(nextFound),
		.selectedLength(selectedLength),
		.mode(mode),
		.selected(selected),
		.recording(recording),
		.memFull(memFull),
		.writeEnable(writeEnable),
		.readEnable(readEnable),
		.commit(commit),
		.clearOne(clearOne),
		.clearAll(clearAll),
		.memSlot(memSlot),
		.memOffset(memOffset),
		.commitLength(commitLength),
		.writeData(writeData),
		.sampleOut(sampleOut),
		.sampleOutStrobe(sampleOutStrobe)
	);

	messageTable #(
		.SlotDepth(SlotDepth)
	) messages (
		.clkout(clkout),
		.reset(reset),
		.commit(commit),
		.clearOne(clearOne),
		.clearAll(clearAll),
		.writeSlot(memSlot),
		.selected(selected),
		.commitLength(commitLength),
		.slotValid(slotValid),
		.freeSlot(freeSlot),
		.nextValid(nextValid),
		.anyFree(anyFree),
		.nextFound(nextFound),
		.selectedLength(selectedLength)
	);

	sampleMemory #(
		.SlotDepth(SlotDepth)
	) memory (
		.clkout(clkout),
		.writeEnable(writeEnable),
		.readEnable(readEnable),
		.slot(memSlot),
		.offset(memOffset),
		.writeData(writeData),
		.readData(readData)
	);

endmodule

`default_nettype wire

//--- sim/tbVoiceRecorder.sv
`timescale 1ns/1ns
`default_nettype none

module tbVoiceRecorder;

	typedef logic [127:0] Word;

	localparam int HoldCycles = 8;
	localparam int IdleCycles = 3;
	localparam int SettleCycles = 2;
	localparam int CyclesPerLine = 40;

	logic clkout;
	logic reset;
	logic btnUp;
	logic btnDown;
	logic btnCentre;
	logic btnLeft;
	logic btnRight;
	logic sampleStrobe;
	recorderPkg::Sample sampleIn;
	recorderPkg::Sample sampleOut;
	logic sampleOutStrobe;
	logic recording;
	logic memFull;
	recorderPkg::Mode mode;
	recorderPkg::SlotIndex selected;
	logic [recorderPkg::SlotCount-1:0] slotValid;

	// trace entries, one per line that is not a comment
	Word kinds [$];
	Word names [$];
	logic [31:0] values [$];

	// samples seen on sampleOut, oldest first
	recorderPkg::Sample outputs [$];

	int cycleCount = 0;
	int cycleLimit = 0;
	int testErrors = 0;
	int totalErrors = 0;
	int testsPassed = 0;
	int testsFailed = 0;
	int testIndex = 0;
	bit testOpen = 1'b0;
	Word testName;

	voiceRecorder #(
		.SlotDepth(4),
		.DebounceCycles(4)
	) DUT (
		.clkout(clkout),
		.reset(reset),
		.btnUp(btnUp),
		.btnDown(btnDown),
		.btnCentre(btnCentre),
		.btnLeft(btnLeft),
		.btnRight(btnRight),
		.sampleStrobe(sampleStrobe),
		.sampleIn(sampleIn),
		.sampleOut(sampleOut),
		.sampleOutStrobe(sampleOutStrobe),
		.recording(recording),
		.memFull(memFull),
		.mode(mode),
		.selected(selected),
		.slotValid(slotValid)
	);

	initial begin
		clkout = 1'b0;
		forever #20 clkout = ~clkout;
	end

	always @(posedge clkout) begin
		if (reset && sampleOutStrobe) begin
			outputs.push_back(sampleOut);
		end
	end

	always @(posedge clkout) begin
		cycleCount <= cycleCount + 1;
		if (cycleLimit != 0 && cycleCount >= cycleLimit) begin
			$display("timeout: the trace did not finish within %0d cycles", cycleLimit);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// trace reader

	function automatic bit loadTrace();
		int fd;
		int n;
		logic [639:0] line;
		Word kind;
		Word name;
		logic [31:0] value;
		fd = $fopen("sim/recorderTrace.txt", "r");
		if (fd == 0) begin
			return 1'b0;
		end
		line = '0;
		while ($fgets(line, fd) != 0) begin
			kind = '0;
			name = '0;
			value = '0;
			n = $sscanf(line, "%s", kind);
			if (n == 1 && kind != Word'("#")) begin
				// press has a decimal repeat count, the rest take hex
				if (kind == Word'("sample")) begin
					n = $sscanf(line, "%s %h", kind, value);
				end else if (kind == Word'("press")) begin
					n = $sscanf(line, "%s %s %d", kind, name, value);
					if (n < 3) begin
						value = 32'd1;
					end
				end else begin
					n = $sscanf(line, "%s %s %h", kind, name, value);
				end
				kinds.push_back(kind);
				names.push_back(name);
				values.push_back(value);
			end
			line = '0;
		end
		$fclose(fd);
		return 1'b1;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// stimulus and checks

	task automatic noteError();
		testErrors++;
		totalErrors++;
	endtask

	task automatic setButton(input Word name, input logic level, output bit known);
		known = 1'b1;
		case (name)
			Word'("up"): btnUp <= level;
			Word'("down"): btnDown <= level;
			Word'("centre"): btnCentre <= level;
			Word'("left"): btnLeft <= level;
			Word'("right"): btnRight <= level;
			default: known = 1'b0;
		endcase
	endtask

	// press then release, the DUT acts on the release
	task automatic pressButton(input Word name, input int count);
		bit known;
		known = 1'b1;
		for (int i = 0; i < count && known; i++) begin
			@(posedge clkout);
			setButton(name, 1'b1, known);
			repeat (HoldCycles) @(posedge clkout);
			setButton(name, 1'b0, known);
			repeat (HoldCycles) @(posedge clkout);
		end
		if (!known) begin
			$display("the trace presses a button that does not exist: %0s", name);
			noteError();
		end
	endtask

	task automatic sendSample(input logic [31:0] value);
		@(posedge clkout);
		sampleStrobe <= 1'b1;
		sampleIn <= recorderPkg::Sample'(value);
		@(posedge clkout);
		sampleStrobe <= 1'b0;
		repeat (IdleCycles) @(posedge clkout);
	endtask

	task automatic checkPort(input Word port, input logic [31:0] want);
		logic [31:0] got;
		bit checkable;
		got = '0;
		checkable = 1'b1;
		repeat (SettleCycles) @(posedge clkout);
		@(negedge clkout);
		case (port)
			Word'("mode"): got = 32'(mode);
			Word'("selected"): got = 32'(selected);
			Word'("slotValid"): got = 32'(slotValid);
			Word'("memFull"): got = 32'(memFull);
			Word'("recording"): got = 32'(recording);
			Word'("sampleOutStrobe"): got = 32'(sampleOutStrobe);
			Word'("noOutput"): got = 32'(outputs.size());
			Word'("sampleOut"): begin
				if (outputs.size() == 0) begin
					$display("at %0t ns sampleOut %h was expected but no sample came out",
						$time, want);
					noteError();
					checkable = 1'b0;
				end else begin
					got = 32'(outputs.pop_front());
				end
			end
			default: begin
				$display("the trace expects a port that the DUT does not have: %0s", port);
				noteError();
				checkable = 1'b0;
			end
		endcase
		if (checkable) begin
			assert (got == want) else begin
				$display("[ERROR] %0t ns: %0s is %0h, expected %0h", $time, port, got, want);
				noteError();
			end
		end
	endtask

	task automatic finishTest();
		if (testOpen) begin
			if (testErrors == 0) begin
				testsPassed++;
				$display("test %0d %0s: passed", testIndex, testName);
			end else begin
				testsFailed++;
				$display("test %0d %0s: failed with %0d errors", testIndex, testName, testErrors);
			end
		end
		testOpen = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence

	initial begin
		reset = 1'b0;
		btnUp = 1'b0;
		btnDown = 1'b0;
		btnCentre = 1'b0;
		btnLeft = 1'b0;
		btnRight = 1'b0;
		sampleStrobe = 1'b0;
		sampleIn = '0;
		if (!loadTrace()) begin
			$display("could not open the trace file sim/recorderTrace.txt");
			$display("STATUS: FAIL");
			$finish;
		end else begin
			cycleLimit = kinds.size() * CyclesPerLine;
			repeat (2) @(posedge clkout);
			reset <= 1'b1;
			for (int i = 0; i < kinds.size(); i++) begin
				case (kinds[i])
					Word'("test"): begin
						finishTest();
						testIndex++;
						testName = names[i];
						testErrors = 0;
						testOpen = 1'b1;
					end
					Word'("press"): pressButton(names[i], int'(values[i]));
					Word'("sample"): sendSample(values[i]);
					Word'("expect"): checkPort(names[i], values[i]);
					default: begin
						$display("the trace has a line of unknown kind: %0s", kinds[i]);
						noteError();
					end
				endcase
			end
			finishTest();
			$display("tests passed: %0d, tests failed: %0d", testsPassed, testsFailed);
			if (testsFailed == 0 && totalErrors == 0) begin
				$display("STATUS: PASS");
			end else begin
				$display("STATUS: FAIL");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- sim/recorderTrace.txt
# columns: kind, then a button, port or test name, then a value
# press takes a decimal repeat count, sample and expect take hex
test reset
expect mode 0
expect selected 0
expect slotValid 00
expect memFull 0
expect recording 0
expect sampleOutStrobe 0
test menu
press down
expect mode 0
press up 3
expect mode 3
press up
expect mode 3
press down 2
expect mode 1
test record
press centre
expect recording 1
sample 11
sample 22
sample 33
press left
expect slotValid 01
# second message runs into the slot limit of four
press centre
sample 44
sample 55
sample 66
sample 77
expect recording 0
sample 88
expect slotValid 03
test playback
press down
press centre 2
sample 00
sample 00
sample 00
expect sampleOut 11
expect sampleOut 22
expect sampleOut 33
sample 00
expect noOutput 0
test skip
press left
press up
press centre
sample a1
sample a2
press left
expect slotValid 07
# delete slot 1
press up
press centre
press up
press centre
expect slotValid 05
press left
press down 2
press centre
press down
expect selected 0
press centre
press right
expect selected 2
sample 00
sample 00
sample 00
expect sampleOut a1
expect sampleOut a2
expect noOutput 0
test memFull
press left
press up
press centre
press left
press centre
press left
press centre
press left
expect slotValid 1f
press centre
expect memFull 1
expect recording 0
press left
expect memFull 0
test deleteAll
press up 2
press centre
expect slotValid 00
expect mode 3

//--- all.f
src/recorderPkg.sv
src/buttonDebounce.sv
src/messageTable.sv
src/sampleMemory.sv
src/recorderControl.sv
src/voiceRecorder.sv
sim/tbVoiceRecorder.sv

//--- Makefile
SIM := obj_dir/VtbVoiceRecorder

.PHONY: run clean

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

$(SIM): all.f $(wildcard src/*.sv) $(wildcard sim/*.sv)
	verilator --binary --assert -j 0 --top-module tbVoiceRecorder -f all.f

clean:
	rm -rf obj_dir
